// File: hdl/axi_lite_pkg.sv
package axi_lite_pkg;

	typedef logic [1:0] resp_t;
	typedef logic [2:0] size_t;

	localparam resp_t resp_okay = 2'b00;
	localparam resp_t resp_slverr = 2'b10;

	// bytes per beat as log2
	localparam size_t size_byte = 3'b000;
	localparam size_t size_half = 3'b001;
	localparam size_t size_word = 3'b010;

	localparam int unsigned sram_words = 256;
	localparam logic [31:0] sram_base = 32'h8000_0000;
	localparam int unsigned read_latency = 2; // ar accept to rvalid

endpackage

// File: hdl/axi_lite_sram.sv
module axi_lite_sram (
	input logic clk,
	input logic rst,

	input lsu_pkg::addr_t araddr,
	input axi_lite_pkg::size_t arsize,
	input logic arvalid,
	output logic arready,
	output lsu_pkg::data_t rdata,
	output axi_lite_pkg::resp_t rresp,
	output logic rvalid,
	input logic rready,

	input lsu_pkg::addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input lsu_pkg::data_t wdata,
	input lsu_pkg::strb_t wstrb,
	input logic wvalid,
	output logic wready,

	output axi_lite_pkg::resp_t bresp,
	output logic bvalid,
	input logic bready
);

	lsu_pkg::data_t mem [axi_lite_pkg::sram_words];

	logic aw_held;
	logic w_held;
	logic w_wait;
	lsu_pkg::addr_t aw_addr;
	lsu_pkg::data_t w_data;
	lsu_pkg::strb_t w_strb;
	lsu_pkg::addr_t ar_addr;
	axi_lite_pkg::size_t ar_size;
	logic [3:0] rd_cnt;

	function automatic logic in_range(lsu_pkg::addr_t a);
		return a >= axi_lite_pkg::sram_base
			&& a < axi_lite_pkg::sram_base + 4 * axi_lite_pkg::sram_words;
	endfunction

	function automatic logic [$clog2(axi_lite_pkg::sram_words)-1:0] word_idx(lsu_pkg::addr_t a);
		lsu_pkg::addr_t rel;
		rel = a - axi_lite_pkg::sram_base;
		return rel[$clog2(axi_lite_pkg::sram_words)+1:2];
	endfunction

	// only the lanes covered by the read size are driven
	function automatic lsu_pkg::data_t lane_mask(axi_lite_pkg::size_t size, logic [1:0] off);
		case (size)
			axi_lite_pkg::size_byte: return lsu_pkg::data_t'(32'h0000_00ff) << {off, 3'b000};
			axi_lite_pkg::size_half: return off[1] ? 32'hffff_0000 : 32'h0000_ffff;
			default: return 32'hffff_ffff;
		endcase
	endfunction

	assign awready = !aw_held;
	assign wready = w_wait && !w_held; // one wait cycle before w is taken
	assign arready = rd_cnt == 4'd0 && !rvalid;

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			w_wait <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (awvalid && awready) begin
				aw_held <= 1'b1;
			end
			if (wvalid && wready) begin
				w_held <= 1'b1;
				w_wait <= 1'b0;
			end else if (wvalid && !w_held) begin
				w_wait <= 1'b1;
			end
			if (aw_held && w_held && !bvalid) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (awvalid && awready) begin
			aw_addr <= awaddr;
		end
		if (wvalid && wready) begin
			w_data <= wdata;
			w_strb <= wstrb;
		end
		if (aw_held && w_held && !bvalid) begin
			if (in_range(aw_addr)) begin
				for (int i = 0; i < 4; i++) begin
					if (w_strb[i]) begin
						mem[word_idx(aw_addr)][8*i +: 8] <= w_data[8*i +: 8];
					end
				end
				bresp <= axi_lite_pkg::resp_okay;
			end else begin
				bresp <= axi_lite_pkg::resp_slverr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_cnt <= 4'd0;
			rvalid <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				rd_cnt <= 4'(axi_lite_pkg::read_latency);
			end else if (rd_cnt != 4'd0) begin
				rd_cnt <= rd_cnt - 4'd1;
				if (rd_cnt == 4'd1) begin
					rvalid <= 1'b1;
				end
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			ar_addr <= araddr;
			ar_size <= arsize;
		end
		if (rd_cnt == 4'd1) begin
			if (in_range(ar_addr)) begin
				rdata <= mem[word_idx(ar_addr)] & lane_mask(ar_size, ar_addr[1:0]);
				rresp <= axi_lite_pkg::resp_okay;
			end else begin
				rdata <= '0;
				rresp <= axi_lite_pkg::resp_slverr;
			end
		end
	end

endmodule

// File: hdl/load_extend.sv
module load_extend (
	input logic clk,
	input lsu_pkg::load_op_t load_op,
	input logic [1:0] offset,
	input lsu_pkg::data_t rdata,
	input logic capture,
	output lsu_pkg::data_t load_data
);

	logic [7:0] byte_sel;
	logic [15:0] half_sel;
	lsu_pkg::data_t extended;

	assign byte_sel = 8'(rdata >> {offset, 3'b000});
	assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0]; // bit 0 ignored

	always_comb begin
		case (load_op)
			lsu_pkg::load_byte: begin
				extended = {{24{byte_sel[7]}}, byte_sel};
			end
			lsu_pkg::load_half: begin
				extended = {{16{half_sel[15]}}, half_sel};
			end
			lsu_pkg::load_byte_u: begin
				extended = {24'h000000, byte_sel};
			end
			lsu_pkg::load_half_u: begin
				extended = {16'h0000, half_sel};
			end
			default: begin
				extended = rdata; // word
			end
		endcase
	end

	// held here while writeback stalls
	always_ff @(posedge clk) begin
		if (capture) begin
			load_data <= extended;
		end
	end

endmodule

// File: hdl/lsu.sv
module lsu (
	input logic clk,
	input logic rst,

	input logic req_valid,
	output logic req_ready,
	input lsu_pkg::load_op_t load_op,
	input lsu_pkg::store_op_t store_op,
	input lsu_pkg::data_t result,
	input lsu_pkg::data_t store_data,
	input lsu_pkg::reg_idx_t rd,
	input logic reg_write,

	output logic out_valid,
	input logic out_ready,
	output lsu_pkg::data_t out_result,
	output lsu_pkg::reg_idx_t out_rd,
	output logic out_reg_write,
	output logic out_fault,

	output lsu_pkg::addr_t araddr,
	output axi_lite_pkg::size_t arsize,
	output logic arvalid,
	input logic arready,
	input lsu_pkg::data_t rdata,
	input axi_lite_pkg::resp_t rresp,
	input logic rvalid,
	output logic rready,

	output lsu_pkg::addr_t awaddr,
	output logic awvalid,
	input logic awready,
	output lsu_pkg::data_t wdata,
	output lsu_pkg::strb_t wstrb,
	output logic wvalid,
	input logic wready,

	input axi_lite_pkg::resp_t bresp,
	input logic bvalid,
	output logic bready
);

	lsu_pkg::lsu_state_t state;
	lsu_pkg::lsu_state_t next_state;
	logic is_load;
	logic is_store;
	logic idle_req;
	logic fault;
	lsu_pkg::data_t load_data;

	function automatic lsu_pkg::lsu_state_t write_issue(logic aw_rdy, logic w_rdy);
		case ({aw_rdy, w_rdy})
			2'b11: return lsu_pkg::s_wait_b;
			2'b10: return lsu_pkg::s_wait_w;
			2'b01: return lsu_pkg::s_wait_aw;
			default: return lsu_pkg::s_wait_aw_w;
		endcase
	endfunction

	assign is_load = load_op != lsu_pkg::load_none;
	assign is_store = store_op != lsu_pkg::store_none;
	assign idle_req = state == lsu_pkg::s_idle && req_valid;

	assign arvalid = state == lsu_pkg::s_wait_ar || (idle_req && is_load);
	assign awvalid = state == lsu_pkg::s_wait_aw_w || state == lsu_pkg::s_wait_aw
		|| (idle_req && !is_load && is_store);
	assign wvalid = state == lsu_pkg::s_wait_aw_w || state == lsu_pkg::s_wait_w
		|| (idle_req && !is_load && is_store);
	assign rready = state == lsu_pkg::s_wait_r;
	assign bready = state == lsu_pkg::s_wait_b;

	// non-memory ops bypass straight to writeback
	assign out_valid = state == lsu_pkg::s_wait_wb || (idle_req && !is_load && !is_store);
	assign req_ready = out_valid && out_ready;
	assign out_result = is_load ? load_data : result;
	assign out_rd = rd;
	assign out_reg_write = reg_write;
	assign out_fault = fault && state == lsu_pkg::s_wait_wb;

	assign araddr = result;
	assign awaddr = result;

	always_comb begin
		case (load_op)
			lsu_pkg::load_byte, lsu_pkg::load_byte_u: arsize = axi_lite_pkg::size_byte;
			lsu_pkg::load_half, lsu_pkg::load_half_u: arsize = axi_lite_pkg::size_half;
			default: arsize = axi_lite_pkg::size_word;
		endcase
	end

	store_align i_store_align (
		.store_op(store_op),
		.offset(result[1:0]),
		.store_data(store_data),
		.wstrb(wstrb),
		.wdata(wdata)
	);

	load_extend i_load_extend (
		.clk(clk),
		.load_op(load_op),
		.offset(result[1:0]),
		.rdata(rdata),
		.capture(rvalid && rready), // accepted read beat
		.load_data(load_data)
	);

	always_comb begin
		next_state = state;
		case (state)
			lsu_pkg::s_idle: begin
				if (req_valid) begin
					if (is_load) begin
						next_state = arready ? lsu_pkg::s_wait_r : lsu_pkg::s_wait_ar;
					end else if (is_store) begin
						next_state = write_issue(awready, wready);
					end else if (!out_ready) begin
						next_state = lsu_pkg::s_wait_wb;
					end
				end
			end
			lsu_pkg::s_wait_ar: if (arready) next_state = lsu_pkg::s_wait_r;
			lsu_pkg::s_wait_r: if (rvalid) next_state = lsu_pkg::s_wait_wb; // any resp ends it
			lsu_pkg::s_wait_aw_w: next_state = write_issue(awready, wready);
			lsu_pkg::s_wait_aw: if (awready) next_state = lsu_pkg::s_wait_b;
			lsu_pkg::s_wait_w: if (wready) next_state = lsu_pkg::s_wait_b;
			lsu_pkg::s_wait_b: if (bvalid) next_state = lsu_pkg::s_wait_wb;
			lsu_pkg::s_wait_wb: if (out_ready) next_state = lsu_pkg::s_idle;
			default: next_state = lsu_pkg::s_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= lsu_pkg::s_idle;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fault <= 1'b0;
		end else if (state == lsu_pkg::s_idle) begin
			fault <= 1'b0;
		end else if (rvalid && rready) begin
			fault <= rresp != axi_lite_pkg::resp_okay;
		end else if (bvalid && bready) begin
			fault <= bresp != axi_lite_pkg::resp_okay;
		end
	end

endmodule

// File: hdl/lsu_pkg.sv
package lsu_pkg;

	typedef logic [31:0] data_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] strb_t; // one bit per byte lane

	typedef enum logic [2:0] {
		load_none   = 3'd0,
		load_byte   = 3'd1,
		load_half   = 3'd2,
		load_word   = 3'd3,
		load_byte_u = 3'd4,
		load_half_u = 3'd5
	} load_op_t;

	typedef enum logic [1:0] {
		store_none = 2'd0,
		store_byte = 2'd1,
		store_half = 2'd2,
		store_word = 2'd3
	} store_op_t;

	typedef enum logic [2:0] {
		s_idle,
		s_wait_ar,
		s_wait_r,
		s_wait_aw_w, // neither write channel taken yet
		s_wait_aw,
		s_wait_w,
		s_wait_b,
		s_wait_wb
	} lsu_state_t;

endpackage

// File: hdl/lsu_top.sv
module lsu_top (
	input logic clk,
	input logic rst,

	input logic req_valid,
	output logic req_ready,
	input lsu_pkg::load_op_t load_op,
	input lsu_pkg::store_op_t store_op,
	input lsu_pkg::data_t result,
	input lsu_pkg::data_t store_data,
	input lsu_pkg::reg_idx_t rd,
	input logic reg_write,

	output logic out_valid,
	input logic out_ready,
	output lsu_pkg::data_t out_result,
	output lsu_pkg::reg_idx_t out_rd,
	output logic out_reg_write,
	output logic out_fault
);

	lsu_pkg::addr_t araddr;
	axi_lite_pkg::size_t arsize;
	logic arvalid;
	logic arready;
	lsu_pkg::data_t rdata;
	axi_lite_pkg::resp_t rresp;
	logic rvalid;
	logic rready;
	lsu_pkg::addr_t awaddr;
	logic awvalid;
	logic awready;
	lsu_pkg::data_t wdata;
	lsu_pkg::strb_t wstrb;
	logic wvalid;
	logic wready;
	axi_lite_pkg::resp_t bresp;
	logic bvalid;
	logic bready;

	lsu i_lsu (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.load_op(load_op),
		.store_op(store_op),
		.result(result),
		.store_data(store_data),
		.rd(rd),
		.reg_write(reg_write),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_result(out_result),
		.out_rd(out_rd),
		.out_reg_write(out_reg_write),
		.out_fault(out_fault),
		.araddr(araddr),
		.arsize(arsize),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready)
	);

	axi_lite_sram i_sram (
		.clk(clk),
		.rst(rst),
		.araddr(araddr),
		.arsize(arsize),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready)
	);

endmodule

// File: hdl/store_align.sv
module store_align (
	input lsu_pkg::store_op_t store_op,
	input logic [1:0] offset,
	input lsu_pkg::data_t store_data,
	output lsu_pkg::strb_t wstrb,
	output lsu_pkg::data_t wdata
);

	always_comb begin
		case (store_op)
			lsu_pkg::store_byte: begin
				wstrb = lsu_pkg::strb_t'(4'b0001 << offset);
				wdata = lsu_pkg::data_t'(store_data[7:0]) << {offset, 3'b000};
			end
			lsu_pkg::store_half: begin
				if (offset[1]) begin // upper half-word
					wstrb = 4'b1100;
					wdata = {store_data[15:0], 16'h0000};
				end else begin
					wstrb = 4'b0011;
					wdata = {16'h0000, store_data[15:0]};
				end
			end
			lsu_pkg::store_word: begin
				wstrb = 4'b1111;
				wdata = store_data;
			end
			default: begin
				wstrb = 4'b0000; // no lanes written
				wdata = store_data;
			end
		endcase
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_lsu_top -f tb.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failure"

// File: tb.f
hdl/lsu_pkg.sv
hdl/axi_lite_pkg.sv
hdl/store_align.sv
hdl/load_extend.sv
hdl/lsu.sv
hdl/axi_lite_sram.sv
hdl/lsu_top.sv
test/tb_lsu_top.sv

// File: test/tb_lsu_top.sv
module tb_lsu_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int idx_bits = $clog2(axi_lite_pkg::sram_words);
	localparam int max_wait = 200;
	localparam lsu_pkg::addr_t base = axi_lite_pkg::sram_base;
	localparam lsu_pkg::addr_t last_word = base + 4 * (axi_lite_pkg::sram_words - 1);

	typedef struct {
		lsu_pkg::load_op_t load_op;
		lsu_pkg::store_op_t store_op;
		lsu_pkg::addr_t addr;
		lsu_pkg::data_t data;
		lsu_pkg::reg_idx_t rd;
		logic reg_write;
		int stall; // cycles out_ready stays low once out_valid shows
		lsu_pkg::data_t exp_result;
		logic exp_fault;
	} row_t;

	logic clk = 1'b0;
	logic rst;
	logic req_valid;
	logic req_ready;
	lsu_pkg::load_op_t load_op;
	lsu_pkg::store_op_t store_op;
	lsu_pkg::data_t result;
	lsu_pkg::data_t store_data;
	lsu_pkg::reg_idx_t rd;
	logic reg_write;
	logic out_valid;
	logic out_ready;
	lsu_pkg::data_t out_result;
	lsu_pkg::reg_idx_t out_rd;
	logic out_reg_write;
	logic out_fault;

	row_t rows[$];
	lsu_pkg::data_t shadow [axi_lite_pkg::sram_words];
	logic [31:0] lfsr = 32'hdc18_1ff5;
	int value_errors = 0;
	int other_errors = 0;
	int cur_row = 0;
	bit timed_out = 1'b0;

	lsu_top i_lsu_top (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.load_op(load_op),
		.store_op(store_op),
		.result(result),
		.store_data(store_data),
		.rd(rd),
		.reg_write(reg_write),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_result(out_result),
		.out_rd(out_rd),
		.out_reg_write(out_reg_write),
		.out_fault(out_fault)
	);

	always #4 clk = ~clk; // 8 ns period

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] lfsr_take(int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic addr_in_sram(lsu_pkg::addr_t a);
		return a >= base && a < base + 4 * axi_lite_pkg::sram_words;
	endfunction

	task automatic check_data(string name, lsu_pkg::data_t got, lsu_pkg::data_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("error: %s row %0d got %h expected %h", name, cur_row, got, exp);
		end
	endtask

	task automatic check_rd(string name, lsu_pkg::reg_idx_t got, lsu_pkg::reg_idx_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("error: %s row %0d got %h expected %h", name, cur_row, got, exp);
		end
	endtask

	task automatic check_fault(string name, logic got, logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("error: %s row %0d got %h expected %h", name, cur_row, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("error: %s row %0d got %h expected %h", name, cur_row, got, exp);
		end
	endtask

	task automatic add_row(lsu_pkg::load_op_t lo, lsu_pkg::store_op_t so, lsu_pkg::addr_t a,
			lsu_pkg::data_t d, lsu_pkg::reg_idx_t r, logic rw, int stall);
		row_t row;
		row.load_op = lo;
		row.store_op = so;
		row.addr = a;
		row.data = d;
		row.rd = r;
		row.reg_write = rw;
		row.stall = stall;
		row.exp_result = '0;
		row.exp_fault = 1'b0;
		rows.push_back(row);
	endtask

	task automatic build_table();
		add_row(lsu_pkg::load_none, lsu_pkg::store_none, 32'h1234_5678, '0, 5'd3, 1'b1, 0);
		add_row(lsu_pkg::load_none, lsu_pkg::store_none, lfsr_take(32), '0, 5'd17, 1'b0, 3);
		add_row(lsu_pkg::load_none, lsu_pkg::store_none, 32'hdead_beef, '0, 5'd31, 1'b1,
			int'(lfsr_take(3)) + 1);
		for (int wd = 0; wd < 4; wd++) begin
			add_row(lsu_pkg::load_none, lsu_pkg::store_word, base + 4 * wd, lfsr_take(32),
				5'd0, 1'b0, 0);
		end
		add_row(lsu_pkg::load_none, lsu_pkg::store_word, last_word, lfsr_take(32), 5'd0, 1'b0,
			int'(lfsr_take(2)));
		add_row(lsu_pkg::load_none, lsu_pkg::store_word, base + 8, 32'h7f01_80a5, 5'd0, 1'b0, 0);
		for (int off = 0; off < 4; off++) begin
			add_row(lsu_pkg::load_none, lsu_pkg::store_byte, base + off, lfsr_take(32),
				5'd0, 1'b0, 0);
			add_row(lsu_pkg::load_word, lsu_pkg::store_none, base, '0, 5'd5, 1'b1, 0);
		end
		for (int off = 0; off < 4; off += 2) begin
			add_row(lsu_pkg::load_none, lsu_pkg::store_half, base + 4 + off, lfsr_take(32),
				5'd0, 1'b0, 0);
			add_row(lsu_pkg::load_word, lsu_pkg::store_none, base + 4, '0, 5'd6, 1'b1, 0);
		end
		// word 2 holds a fixed mix of signs, word 0 random bytes
		for (int wd = 0; wd < 3; wd += 2) begin
			for (int off = 0; off < 4; off++) begin
				add_row(lsu_pkg::load_byte, lsu_pkg::store_none, base + 4 * wd + off, '0,
					5'(lfsr_take(5)), 1'b1, 0);
				add_row(lsu_pkg::load_byte_u, lsu_pkg::store_none, base + 4 * wd + off, '0,
					5'(lfsr_take(5)), 1'b1, 0);
			end
			for (int off = 0; off < 4; off += 2) begin
				add_row(lsu_pkg::load_half, lsu_pkg::store_none, base + 4 * wd + off, '0,
					5'(lfsr_take(5)), 1'b1, 0);
				add_row(lsu_pkg::load_half_u, lsu_pkg::store_none, base + 4 * wd + off, '0,
					5'(lfsr_take(5)), 1'b1, 0);
			end
		end
		add_row(lsu_pkg::load_word, lsu_pkg::store_none, last_word, '0, 5'd8, 1'b1, 0);
		// just past the top, then far below the base
		add_row(lsu_pkg::load_word, lsu_pkg::store_none, last_word + 4, '0, 5'd9, 1'b1, 0);
		add_row(lsu_pkg::load_word, lsu_pkg::store_none, base + 12, '0, 5'd10, 1'b1, 0);
		add_row(lsu_pkg::load_none, lsu_pkg::store_word, 32'h0000_0100, lfsr_take(32),
			5'd0, 1'b0, 0);
		add_row(lsu_pkg::load_byte_u, lsu_pkg::store_none, base + 13, '0, 5'd11, 1'b1, 0);
		add_row(lsu_pkg::load_half, lsu_pkg::store_none, base + 10, '0, 5'd12, 1'b1, 6);
		add_row(lsu_pkg::load_none, lsu_pkg::store_byte, base + 15, lfsr_take(32), 5'd0, 1'b0,
			5);
		add_row(lsu_pkg::load_word, lsu_pkg::store_none, base + 12, '0, 5'd13, 1'b1, 4);
	endtask

	// walks the table in order against the shadow memory
	task automatic fill_expected();
		lsu_pkg::data_t w;
		logic [idx_bits-1:0] idx;
		logic [1:0] off;
		int lane;
		logic [7:0] b;
		logic [15:0] h;
		for (int i = 0; i < rows.size(); i++) begin
			idx = idx_bits'((rows[i].addr - base) >> 2);
			off = rows[i].addr[1:0];
			lane = 8 * off;
			w = shadow[idx];
			b = w[lane +: 8];
			h = off[1] ? w[31:16] : w[15:0];
			rows[i].exp_result = rows[i].addr; // non-memory and stores pass result
			rows[i].exp_fault = 1'b0;
			if (rows[i].load_op != lsu_pkg::load_none
					|| rows[i].store_op != lsu_pkg::store_none) begin
				rows[i].exp_fault = !addr_in_sram(rows[i].addr);
			end
			if (rows[i].load_op != lsu_pkg::load_none) begin
				if (rows[i].exp_fault) begin
					rows[i].exp_result = '0;
				end else begin
					case (rows[i].load_op)
						lsu_pkg::load_byte: rows[i].exp_result = {{24{b[7]}}, b};
						lsu_pkg::load_byte_u: rows[i].exp_result = {24'h000000, b};
						lsu_pkg::load_half: rows[i].exp_result = {{16{h[15]}}, h};
						lsu_pkg::load_half_u: rows[i].exp_result = {16'h0000, h};
						default: rows[i].exp_result = w;
					endcase
				end
			end else if (rows[i].store_op != lsu_pkg::store_none && !rows[i].exp_fault) begin
				case (rows[i].store_op)
					lsu_pkg::store_byte: w[lane +: 8] = rows[i].data[7:0];
					lsu_pkg::store_half: begin
						if (off[1]) begin
							w[31:16] = rows[i].data[15:0];
						end else begin
							w[15:0] = rows[i].data[15:0];
						end
					end
					default: w = rows[i].data;
				endcase
				shadow[idx] = w;
			end
		end
	endtask

	task automatic apply_row(int i);
		int cycles;
		lsu_pkg::data_t held_result;
		lsu_pkg::reg_idx_t held_rd;
		logic held_rw;
		logic held_fault;
		cur_row = i;
		@(posedge clk);
		#1;
		req_valid = 1'b1;
		load_op = rows[i].load_op;
		store_op = rows[i].store_op;
		result = rows[i].addr;
		store_data = rows[i].data;
		rd = rows[i].rd;
		reg_write = rows[i].reg_write;
		out_ready = rows[i].stall == 0;
		cycles = 0;
		@(negedge clk);
		while (out_valid !== 1'b1 && cycles < max_wait) begin
			check_flag("req_ready", req_ready, 1'b0);
			@(negedge clk);
			cycles++;
		end
		if (out_valid !== 1'b1) begin
			$display("row %0d saw no out_valid within %0d cycles", i, max_wait);
			other_errors++;
			timed_out = 1'b1;
		end else begin
			held_result = out_result;
			held_rd = out_rd;
			held_rw = out_reg_write;
			held_fault = out_fault;
			for (int s = 0; s < rows[i].stall; s++) begin
				check_flag("out_valid", out_valid, 1'b1);
				check_flag("req_ready", req_ready, 1'b0);
				if (out_result !== held_result || out_rd !== held_rd
						|| out_reg_write !== held_rw || out_fault !== held_fault) begin
					$display("row %0d outputs changed while writeback was stalled", i);
					other_errors++;
				end
				@(posedge clk);
				#1;
				if (s == rows[i].stall - 1) begin
					out_ready = 1'b1;
				end
				@(negedge clk);
			end
			check_flag("out_valid", out_valid, 1'b1);
			check_flag("req_ready", req_ready, 1'b1); // transfer cycle
			check_data("out_result", out_result, rows[i].exp_result);
			check_rd("out_rd", out_rd, rows[i].rd);
			check_flag("out_reg_write", out_reg_write, rows[i].reg_write);
			check_fault("out_fault", out_fault, rows[i].exp_fault);
			@(posedge clk);
			#1;
			req_valid = 1'b0;
			out_ready = 1'b0;
		end
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		load_op = lsu_pkg::load_none;
		store_op = lsu_pkg::store_none;
		result = '0;
		store_data = '0;
		rd = '0;
		reg_write = 1'b0;
		out_ready = 1'b0;
		build_table();
		fill_expected();
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			if (!timed_out) begin
				apply_row(i);
			end
		end
		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
